// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_transfer
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== phase_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_timer #(
    parameter int PHASES = 5
) (
    input  logic sim_clk,
    input  logic arst_n,
    output logic bit_tick
);

    localparam int CNT_W = $clog2(PHASES);
    localparam logic [CNT_W-1:0] LAST_PHASE = CNT_W'(PHASES - 1);

    logic [CNT_W-1:0] phase_cnt;
    logic             at_last;

    assign at_last = (phase_cnt == LAST_PHASE);

    // Free-running phase counter within one bit time
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_cnt <= '0;
        end else if (at_last) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // One pulse per bit time
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_tick <= 1'b0;
        end else begin
            bit_tick <= at_last;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
tr_pkg.sv
phase_timer.sv
transfer_sequencer.sv
transfer_reg.sv
transfer_top.sv
tb_transfer.sv

// ==== tb_transfer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_transfer;

    import tr_pkg::*;

    localparam int PHASES          = 5;
    localparam int NUM_TESTS       = 7;
    localparam int DONE_LIMIT      = 12 * PHASES;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 12 * PHASES + 100;
    localparam int SEED            = 74909;

    logic                sim_clk;
    logic                arst_n;
    logic                cmd_valid;
    tr_cmd_e             cmd;
    logic [TR_WIDTH-1:0] buf_a;
    logic [TR_WIDTH-1:0] buf_b;
    logic                din;
    logic [TR_WIDTH-1:0] tr_word;
    logic [OP_W-1:0]     tr_op;
    logic [ADDR_W-1:0]   tr_addr;
    logic                all_ones;
    logic                dout;
    logic                busy;
    logic                done;

    logic [TR_WIDTH-1:0] exp_word;  // Reference model state
    logic                exp_dout;

    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    int    cyc;          // Clock edges since reset release
    int    done_pulses;

    transfer_top #(
        .PHASES (PHASES)
    ) dut_i (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .buf_a     (buf_a),
        .buf_b     (buf_b),
        .din       (din),
        .tr_word   (tr_word),
        .tr_op     (tr_op),
        .tr_addr   (tr_addr),
        .all_ones  (all_ones),
        .dout      (dout),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        sim_clk = 1'b0;
        forever #50 sim_clk = ~sim_clk;
    end

    // Bit tick falls in every cycle where cyc is a nonzero multiple of PHASES
    always @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(negedge sim_clk) begin
        if (!arst_n) begin
            done_pulses <= 0;
        end else if (done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("MISMATCH %s: %s expected=0x%0h actual=0x%0h",
                 test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    // Results at done are sampled mid-cycle where everything is settled
    a_word: assert property (@(negedge sim_clk) disable iff (!arst_n)
        done |-> (tr_word == exp_word))
        else report_mismatch("tr_word", int'(exp_word), int'(tr_word));

    a_syllable: assert property (@(negedge sim_clk) disable iff (!arst_n)
        done |-> ({tr_op, tr_addr} == exp_word))
        else report_mismatch("tr_op/tr_addr", int'(exp_word), int'({tr_op, tr_addr}));

    a_all_ones: assert property (@(negedge sim_clk) disable iff (!arst_n)
        done |-> (all_ones == &exp_word))
        else report_mismatch("all_ones", int'(&exp_word), int'(all_ones));

    a_dout: assert property (@(negedge sim_clk) disable iff (!arst_n)
        done |-> (dout == exp_dout))
        else report_mismatch("dout", int'(exp_dout), int'(dout));

    a_done_width: assert property (@(negedge sim_clk) disable iff (!arst_n)
        done |=> !done)
        else report_failure("done stayed high for more than one cycle");

    a_done_busy: assert property (@(negedge sim_clk) disable iff (!arst_n)
        done == $fell(busy))
        else report_failure("done and the falling edge of busy do not coincide");

    a_busy_rise: assert property (@(negedge sim_clk) disable iff (!arst_n)
        $rose(busy) |-> $past(cmd_valid && !busy))
        else report_failure("busy rose without an accepted command");

    task automatic model_load(input logic [TR_WIDTH-1:0] value);
        exp_dout = exp_word[TR_WIDTH-1];
        exp_word = value;
    endtask

    task automatic model_clear();
        exp_dout = exp_word[TR_WIDTH-1];
        exp_word = '0;
    endtask

    // First bit in ends up in bit 9
    task automatic model_shift(input logic [TR_WIDTH-1:0] bits);
        int i;
        exp_dout = exp_word[0];
        for (i = 0; i < TR_WIDTH; i++) begin
            exp_word[TR_WIDTH-1-i] = bits[i];
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("[fail] %s (%0d errors)", test_name, errors - errors_at_start);
        end else begin
            $display("[ok]   %s", test_name);
        end
    endtask

    // Called just after a rising edge and returns in the cycle after acceptance
    task automatic issue_cmd(input tr_cmd_e c);
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge sim_clk);
        #10;
        cmd_valid = 1'b0;
        assert (busy) else report_failure("busy did not rise after an accepted command");
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(posedge sim_clk);
            #10;
            n++;
        end
        if (!done) begin
            report_failure($sformatf("no done pulse within %0d cycles", limit));
        end else begin
            @(posedge sim_clk);
            #10;
        end
    endtask

    task automatic run_load_test(input tr_cmd_e c, input int count);
        logic [31:0]         r;
        logic [TR_WIDTH-1:0] value;
        repeat (count) begin
            r     = $urandom();
            value = r[TR_WIDTH-1:0];
            buf_a = (c == CMD_LOAD_A) ? value : ~value;  // Other buffer must not leak in
            buf_b = (c == CMD_LOAD_B) ? value : ~value;
            model_load(value);
            issue_cmd(c);
            wait_done(DONE_LIMIT);
            assert (tr_op == value[TR_WIDTH-1:ADDR_W])
                else report_mismatch("tr_op", int'(value[TR_WIDTH-1:ADDR_W]), int'(tr_op));
            assert (tr_addr == value[ADDR_W-1:0])
                else report_mismatch("tr_addr", int'(value[ADDR_W-1:0]), int'(tr_addr));
        end
    endtask

    task automatic run_shift();
        logic [31:0]         r;
        logic [TR_WIDTH-1:0] bits;
        logic [TR_WIDTH-1:0] old_word;
        int                  idx;
        bit                  tick_cycle;
        r        = $urandom();
        bits     = r[TR_WIDTH-1:0];
        old_word = exp_word;
        model_shift(bits);
        din = bits[0];
        issue_cmd(CMD_SHIFT);
        idx = 0;
        while (idx < TR_WIDTH) begin
            tick_cycle = (cyc % PHASES == 0);
            @(posedge sim_clk);
            #10;
            if (tick_cycle) begin
                assert (dout == old_word[TR_WIDTH-1-idx])
                    else report_mismatch($sformatf("dout after bit %0d", idx + 1),
                                         int'(old_word[TR_WIDTH-1-idx]), int'(dout));
                idx++;
                if (idx < TR_WIDTH) begin
                    din = bits[idx];
                end
            end
        end
        wait_done(2 * PHASES);
    endtask

    task automatic run_clear_test();
        buf_a = '1;
        model_load('1);
        issue_cmd(CMD_LOAD_A);
        wait_done(DONE_LIMIT);
        assert (all_ones) else report_mismatch("all_ones after load", 1, int'(all_ones));
        model_clear();
        issue_cmd(CMD_CLEAR);
        wait_done(DONE_LIMIT);
        assert (tr_word == '0) else report_mismatch("tr_word after clear", 0, int'(tr_word));
        assert (!all_ones) else report_mismatch("all_ones after clear", 0, int'(all_ones));
    endtask

    task automatic run_ignored_test();
        logic [31:0]         r;
        logic [TR_WIDTH-1:0] value;
        int                  pulses_before;
        r     = $urandom();
        value = r[TR_WIDTH-1:0] | 9'h100;  // Keep it distinct from a clear
        buf_a = value;
        model_load(value);
        issue_cmd(CMD_LOAD_A);
        pulses_before = done_pulses;
        cmd       = CMD_CLEAR;
        cmd_valid = 1'b1;
        @(posedge sim_clk);
        #10;
        cmd_valid = 1'b0;
        wait_done(DONE_LIMIT);
        repeat (2 * PHASES) @(posedge sim_clk);
        #10;
        assert (done_pulses == pulses_before + 1)
            else report_mismatch("done pulses", pulses_before + 1, done_pulses);
        assert (!busy) else report_failure("busy rose again after the dropped command");
        assert (tr_word == exp_word)
            else report_mismatch("tr_word after dropped command", int'(exp_word), int'(tr_word));
    endtask

    initial begin
        int pulses_before;
        void'($urandom(SEED));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = CMD_LOAD_A;
        buf_a        = '0;
        buf_b        = '0;
        din          = 1'b0;
        exp_word     = '0;
        exp_dout     = 1'b0;
        test_name    = "startup";
        repeat (4) @(posedge sim_clk);
        #10;
        arst_n = 1'b1;

        begin_test("reset");
        assert (!busy) else report_mismatch("busy", 0, int'(busy));
        assert (!done) else report_mismatch("done", 0, int'(done));
        assert (!dout) else report_mismatch("dout", 0, int'(dout));
        assert (!all_ones) else report_mismatch("all_ones", 0, int'(all_ones));
        assert (tr_word == '0) else report_mismatch("tr_word", 0, int'(tr_word));
        end_test();

        begin_test("load_a");
        run_load_test(CMD_LOAD_A, 3);
        end_test();

        begin_test("load_b");
        run_load_test(CMD_LOAD_B, 3);
        end_test();

        begin_test("shift");
        run_shift();
        run_shift();
        end_test();

        begin_test("clear_all_ones");
        run_clear_test();
        end_test();

        begin_test("ignored_cmd");
        run_ignored_test();
        end_test();

        // cmd moves while cmd_valid stays low so nothing may start
        begin_test("idle_hold");
        pulses_before = done_pulses;
        cmd           = CMD_CLEAR;
        repeat (3 * PHASES) @(posedge sim_clk);
        #10;
        assert (!busy) else report_failure("busy rose with cmd_valid low");
        assert (done_pulses == pulses_before)
            else report_mismatch("done pulses", pulses_before, done_pulses);
        assert (tr_word == exp_word)
            else report_mismatch("tr_word", int'(exp_word), int'(tr_word));
        end_test();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sim_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tr_pkg.sv ====
`default_nettype none

package tr_pkg;

    // Register geometry
    parameter int TR_WIDTH = 9;
    parameter int OP_W     = 4;
    parameter int ADDR_W   = TR_WIDTH - OP_W;

    // Shift counter must hold TR_WIDTH-1
    parameter int SHIFT_BITS_W = $clog2(TR_WIDTH);

    typedef enum logic [1:0] {
        CMD_LOAD_A = 2'd0,  // Parallel load from buffer A
        CMD_LOAD_B = 2'd1,  // Parallel load from buffer B
        CMD_SHIFT  = 2'd2,  // Serial shift in from din
        CMD_CLEAR  = 2'd3   // Clear to zero
    } tr_cmd_e;

    // Instruction syllable layout, op in the upper bits
    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [ADDR_W-1:0] addr;
    } tr_syl_t;

    // Same register word seen as data or as a syllable
    typedef union packed {
        logic [TR_WIDTH-1:0] raw;
        tr_syl_t             syl;
    } tr_word_u;

endpackage

`default_nettype wire

// ==== transfer_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module transfer_reg (
    input  logic                         sim_clk,
    input  logic                         arst_n,
    input  logic                         load_a_en,
    input  logic                         load_b_en,
    input  logic                         shift_en,
    input  logic                         clear_en,
    input  logic                         din,
    input  logic [tr_pkg::TR_WIDTH-1:0]  buf_a,
    input  logic [tr_pkg::TR_WIDTH-1:0]  buf_b,
    output tr_pkg::tr_word_u             word,
    output logic                         all_ones,
    output logic                         dout
);

    import tr_pkg::*;

    tr_word_u word_nxt;
    logic     any_en;

    assign any_en = load_a_en | load_b_en | shift_en | clear_en;

    // Next word from the active enable
    always_comb begin
        word_nxt = word;
        if (load_a_en) begin
            word_nxt.raw = buf_a;
        end else if (load_b_en) begin
            word_nxt.raw = buf_b;
        end else if (shift_en) begin
            word_nxt.raw = {word.raw[TR_WIDTH-2:0], din};  // Bit 1 in, toward bit 9
        end else if (clear_en) begin
            word_nxt.raw = '0;
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            word <= '0;
        end else if (any_en) begin
            word <= word_nxt;
        end
    end

    // Bit 9 delayed by one bit time
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= 1'b0;
        end else if (any_en) begin
            dout <= word.raw[TR_WIDTH-1];
        end
    end

    assign all_ones = &word.raw;  // Every bit set

endmodule

`default_nettype wire

// ==== transfer_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module transfer_sequencer (
    input  logic             sim_clk,
    input  logic             arst_n,
    input  logic             bit_tick,
    input  logic             cmd_valid,
    input  tr_pkg::tr_cmd_e  cmd,
    output logic             load_a_en,
    output logic             load_b_en,
    output logic             shift_en,
    output logic             clear_en,
    output logic             busy,
    output logic             done
);

    import tr_pkg::*;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_TICK = 2'd1,
        SHIFTING  = 2'd2
    } seq_state_e;

    localparam logic [SHIFT_BITS_W-1:0] LAST_BIT = SHIFT_BITS_W'(TR_WIDTH - 1);

    seq_state_e              state;
    tr_cmd_e                 cmd_q;
    logic [SHIFT_BITS_W-1:0] shift_cnt;
    logic                    wait_hit;
    logic                    shift_hit;
    logic                    last_shift;

    // Single-tick operation lands on the next bit tick
    assign wait_hit   = (state == WAIT_TICK) && bit_tick;
    assign shift_hit  = (state == SHIFTING) && bit_tick;
    assign last_shift = shift_hit && (shift_cnt == LAST_BIT);

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            cmd_q     <= CMD_LOAD_A;
            shift_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        cmd_q     <= cmd;
                        shift_cnt <= '0;
                        if (cmd == CMD_SHIFT) begin
                            state <= SHIFTING;
                        end else begin
                            state <= WAIT_TICK;
                        end
                    end
                end
                WAIT_TICK: begin
                    if (wait_hit) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                SHIFTING: begin
                    if (last_shift) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end else if (shift_hit) begin
                        shift_cnt <= shift_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Commands in flight are simply dropped
    assign busy = (state != IDLE);

    // Register steering, only ever one enable per bit tick
    assign load_a_en = wait_hit && (cmd_q == CMD_LOAD_A);
    assign load_b_en = wait_hit && (cmd_q == CMD_LOAD_B);
    assign clear_en  = wait_hit && (cmd_q == CMD_CLEAR);
    assign shift_en  = shift_hit;

endmodule

`default_nettype wire

// ==== transfer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module transfer_top #(
    parameter int PHASES = 5
) (
    input  logic                          sim_clk,
    input  logic                          arst_n,
    input  logic                          cmd_valid,
    input  tr_pkg::tr_cmd_e               cmd,
    input  logic [tr_pkg::TR_WIDTH-1:0]   buf_a,
    input  logic [tr_pkg::TR_WIDTH-1:0]   buf_b,
    input  logic                          din,
    output logic [tr_pkg::TR_WIDTH-1:0]   tr_word,
    output logic [tr_pkg::OP_W-1:0]       tr_op,
    output logic [tr_pkg::ADDR_W-1:0]     tr_addr,
    output logic                          all_ones,
    output logic                          dout,
    output logic                          busy,
    output logic                          done
);

    import tr_pkg::*;

    logic     bit_tick;
    logic     load_a_en;
    logic     load_b_en;
    logic     shift_en;
    logic     clear_en;
    tr_word_u word;

    phase_timer #(
        .PHASES (PHASES)
    ) timer_i (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .bit_tick (bit_tick)
    );

    transfer_sequencer seq_i (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .bit_tick  (bit_tick),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .load_a_en (load_a_en),
        .load_b_en (load_b_en),
        .shift_en  (shift_en),
        .clear_en  (clear_en),
        .busy      (busy),
        .done      (done)
    );

    transfer_reg reg_i (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .load_a_en (load_a_en),
        .load_b_en (load_b_en),
        .shift_en  (shift_en),
        .clear_en  (clear_en),
        .din       (din),
        .buf_a     (buf_a),
        .buf_b     (buf_b),
        .word      (word),
        .all_ones  (all_ones),
        .dout      (dout)
    );

    assign tr_word = word.raw;
    assign tr_op   = word.syl.op;    // Syllable view of the same word
    assign tr_addr = word.syl.addr;

endmodule

`default_nettype wire
